// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
src/dcache_pkg.sv
src/dcache_way_ram.sv
src/dcache_lookup.sv
src/dcache_load_ctrl.sv
src/dcache_store_ctrl.sv
src/dcache_arbiter.sv
src/dcache_top.sv
verification/dcache_tb.sv

// File: src/dcache_arbiter.sv
`timescale 1ns/1ps

module dcache_arbiter
    import dcache_pkg::*;
(
    input  logic   clk, arst_n_i,
    input  logic   ld_arb_req_i, st_arb_req_i,
    output logic   ld_grant_o, st_grant_o,
    input  logic   ld_lk_valid_i,
    input  lk_op_e ld_lk_op_i,
    input  addr_t  ld_lk_addr_i,
    input  data_t  ld_lk_data_i,
    input  logic   st_lk_valid_i,
    input  lk_op_e st_lk_op_i,
    input  addr_t  st_lk_addr_i,
    input  data_t  st_lk_data_i,
    input  strb_t  st_lk_strb_i,
    output logic   lk_valid_o,
    output lk_op_e lk_op_o,
    output addr_t  lk_addr_o,
    output data_t  lk_data_o,
    output strb_t  lk_strb_o,
    input  logic   ld_mem_req_valid_i, ld_mem_req_write_i,
    output logic   ld_mem_req_ready_o,
    input  addr_t  ld_mem_req_addr_i,
    input  data_t  ld_mem_req_data_i,
    input  logic   st_mem_req_valid_i, st_mem_req_write_i,
    output logic   st_mem_req_ready_o,
    input  addr_t  st_mem_req_addr_i,
    input  data_t  st_mem_req_data_i,
    output logic   mem_req_valid_o,
    input  logic   mem_req_ready_i,
    output logic   mem_req_write_o,
    output addr_t  mem_req_addr_o,
    output data_t  mem_req_data_o
);

    logic own_ld_q, own_st_q;

    // load wins whenever the store does not already own the arrays
    assign ld_grant_o = ld_arb_req_i && !(own_st_q && st_arb_req_i);
    assign st_grant_o = st_arb_req_i && !ld_grant_o;

    assign lk_valid_o = st_grant_o ? st_lk_valid_i : (ld_grant_o && ld_lk_valid_i);
    assign lk_op_o    = st_grant_o ? st_lk_op_i    : ld_lk_op_i;
    assign lk_addr_o  = st_grant_o ? st_lk_addr_i  : ld_lk_addr_i;
    assign lk_data_o  = st_grant_o ? st_lk_data_i  : ld_lk_data_i;
    assign lk_strb_o  = st_grant_o ? st_lk_strb_i  : '0;

    assign mem_req_valid_o = st_grant_o ? st_mem_req_valid_i :
                             (ld_grant_o && ld_mem_req_valid_i);
    assign mem_req_write_o = st_grant_o ? st_mem_req_write_i : ld_mem_req_write_i;
    assign mem_req_addr_o  = st_grant_o ? st_mem_req_addr_i  : ld_mem_req_addr_i;
    assign mem_req_data_o  = st_grant_o ? st_mem_req_data_i  : ld_mem_req_data_i;

    assign ld_mem_req_ready_o = mem_req_ready_i && ld_grant_o;
    assign st_mem_req_ready_o = mem_req_ready_i && st_grant_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            own_ld_q <= 1'b0;
            own_st_q <= 1'b0;
        end else begin
            own_ld_q <= ld_grant_o;
            own_st_q <= st_grant_o;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n_i) $onehot0({ld_grant_o, st_grant_o}))
        else $error("both controllers granted");

    assert property (@(posedge clk) disable iff (!arst_n_i)
        (own_ld_q && ld_arb_req_i |-> ld_grant_o) and (own_st_q && st_arb_req_i |-> st_grant_o))
        else $error("owner lost the grant during its transaction");

endmodule

// File: src/dcache_load_ctrl.sv
`timescale 1ns/1ps

module dcache_load_ctrl
    import dcache_pkg::*;
(
    input  logic   clk, arst_n_i,
    input  logic   ld_valid_i,
    output logic   ld_ready_o,
    input  addr_t  ld_addr_i,
    output logic   ld_resp_valid_o,
    output data_t  ld_data_o,
    output logic   arb_req_o,
    input  logic   grant_i,
    output logic   lk_valid_o,
    output lk_op_e lk_op_o,
    output addr_t  lk_addr_o,
    output data_t  lk_data_o,
    input  logic   lk_rsp_valid_i, lk_hit_i,
    input  data_t  lk_rdata_i,
    input  logic   lk_wb_need_i,
    input  addr_t  lk_wb_addr_i,
    input  data_t  lk_wb_data_i,
    output logic   mem_req_valid_o,
    input  logic   mem_req_ready_i,
    output logic   mem_req_write_o,
    output addr_t  mem_req_addr_o,
    output data_t  mem_req_data_o,
    input  logic   mem_rsp_valid_i,
    input  data_t  mem_rsp_data_i
);

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT_GRANT, S_PROBE, S_WB, S_REFILL, S_RESP
    } state_e;

    state_e state_q;
    logic   rd_sent_q;
    addr_t  addr_q, wb_addr_q;
    data_t  wb_data_q, data_q;

    assign ld_ready_o      = (state_q == S_IDLE);
    assign ld_resp_valid_o = (state_q == S_RESP);
    assign ld_data_o       = data_q;
    assign arb_req_o       = (state_q != S_IDLE);

    // probe goes out in the grant cycle, fill with the refill response
    assign lk_valid_o = ((state_q == S_WAIT_GRANT) && grant_i) ||
                        ((state_q == S_REFILL) && mem_rsp_valid_i);
    assign lk_op_o    = (state_q == S_REFILL) ? LK_FILL : LK_PROBE;
    assign lk_addr_o  = addr_q;
    assign lk_data_o  = mem_rsp_data_i;

    assign mem_req_valid_o = (state_q == S_WB) || ((state_q == S_REFILL) && !rd_sent_q);
    assign mem_req_write_o = (state_q == S_WB);
    assign mem_req_addr_o  = (state_q == S_WB) ? wb_addr_q :
                             {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_req_data_o  = wb_data_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= S_IDLE;
            rd_sent_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE:
                    if (ld_valid_i)
                        state_q <= S_WAIT_GRANT;
                S_WAIT_GRANT:
                    if (grant_i)
                        state_q <= S_PROBE;
                S_PROBE:
                    if (lk_rsp_valid_i)
                        state_q <= lk_hit_i ? S_RESP : lk_wb_need_i ? S_WB : S_REFILL;
                S_WB:
                    if (mem_req_ready_i)
                        state_q <= S_REFILL;
                S_REFILL: begin
                    if (mem_req_valid_o && mem_req_ready_i)
                        rd_sent_q <= 1'b1;
                    if (mem_rsp_valid_i) begin
                        rd_sent_q <= 1'b0;
                        state_q   <= S_RESP;
                    end
                end
                default:
                    state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ld_valid_i && ld_ready_o)
            addr_q <= ld_addr_i;
        if ((state_q == S_PROBE) && lk_rsp_valid_i) begin
            wb_addr_q <= lk_wb_addr_i;
            wb_data_q <= lk_wb_data_i;
            data_q    <= lk_rdata_i;
        end
        if ((state_q == S_REFILL) && mem_rsp_valid_i)
            data_q <= mem_rsp_data_i;
    end

    assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o &&
            $stable(mem_req_write_o) && $stable(mem_req_addr_o) && $stable(mem_req_data_o))
        else $error("load memory request changed under back-pressure");

endmodule

// File: src/dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   lk_valid_i,
    input  lk_op_e lk_op_i,
    input  addr_t  lk_addr_i,
    input  data_t  lk_data_i,
    input  strb_t  lk_strb_i,
    output logic   lk_rsp_valid_o,
    output logic   lk_hit_o,
    output data_t  lk_rdata_o,
    output logic   lk_wb_need_o,
    output addr_t  lk_wb_addr_o,
    output data_t  lk_wb_data_o
);

    logic [NUM_SETS-1:0] valid_q [2];
    logic [NUM_SETS-1:0] dirty_q [2];
    // index of the least recently used way per set
    logic [NUM_SETS-1:0] lru_q;

    index_t     idx_q;
    tag_t       tag_q;
    logic       hit_way_q;
    logic       vict_way_q;
    logic       probe, fill, write;
    index_t     req_index, rd_index;
    tag_t       req_tag;
    tag_t       way_tag [2];
    data_t      way_data [2];
    logic [1:0] way_hit, tag_we, data_we;
    logic       hit_way, vict_way;
    data_t      byte_mask, merged, wr_data;

    assign probe = lk_valid_i && (lk_op_i == LK_PROBE);
    assign fill  = lk_valid_i && (lk_op_i == LK_FILL);
    assign write = lk_valid_i && (lk_op_i == LK_WRITE);

    assign req_index = lk_addr_i[OFFSET_W +: INDEX_W];
    assign req_tag   = lk_addr_i[ADDR_W-1 -: TAG_W];
    // keep the probed set on the read port, a later merge needs its word
    assign rd_index  = probe ? req_index : idx_q;

    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            byte_mask[8*b +: 8] = {8{lk_strb_i[b]}};
        end
    end

    assign merged  = (way_data[hit_way_q] & ~byte_mask) | (lk_data_i & byte_mask);
    assign wr_data = fill ? lk_data_i : merged;

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign way_hit[w] = valid_q[w][idx_q] && (way_tag[w] == tag_q);
        assign tag_we[w]  = fill && (vict_way_q == 1'(w));
        assign data_we[w] = tag_we[w] || (write && (hit_way_q == 1'(w)));

        dcache_way_ram #(.payload_t(tag_t)) tag_ram_i (
            .clk        (clk),
            .rd_index_i (rd_index),
            .wr_en_i    (tag_we[w]),
            .wr_index_i (idx_q),
            .wr_data_i  (req_tag),
            .rd_data_o  (way_tag[w])
        );

        dcache_way_ram #(.payload_t(data_t)) data_ram_i (
            .clk        (clk),
            .rd_index_i (rd_index),
            .wr_en_i    (data_we[w]),
            .wr_index_i (idx_q),
            .wr_data_i  (wr_data),
            .rd_data_o  (way_data[w])
        );
    end

    assign hit_way  = way_hit[1];
    // invalid way first, way 0 before way 1
    assign vict_way = !valid_q[0][idx_q] ? 1'b0 :
                      !valid_q[1][idx_q] ? 1'b1 : lru_q[idx_q];

    assign lk_hit_o     = |way_hit;
    assign lk_rdata_o   = way_data[hit_way];
    assign lk_wb_need_o = valid_q[vict_way][idx_q] && dirty_q[vict_way][idx_q];
    assign lk_wb_addr_o = {way_tag[vict_way], idx_q, {OFFSET_W{1'b0}}};
    assign lk_wb_data_o = way_data[vict_way];

    always_ff @(posedge clk) begin
        if (probe) begin
            idx_q <= req_index;
            tag_q <= req_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lk_rsp_valid_o <= 1'b0;
            valid_q[0]     <= '0;
            valid_q[1]     <= '0;
            dirty_q[0]     <= '0;
            dirty_q[1]     <= '0;
            lru_q          <= '0;
            hit_way_q      <= 1'b0;
            vict_way_q     <= 1'b0;
        end else begin
            lk_rsp_valid_o <= probe;
            if (lk_rsp_valid_o) begin
                hit_way_q  <= hit_way;
                vict_way_q <= vict_way;
                if (lk_hit_o) begin
                    lru_q[idx_q] <= !hit_way;
                end
            end
            if (fill) begin
                valid_q[vict_way_q][idx_q] <= 1'b1;
                dirty_q[vict_way_q][idx_q] <= 1'b0;
                lru_q[idx_q]               <= !vict_way_q;
            end
            if (write) begin
                dirty_q[hit_way_q][idx_q] <= 1'b1;
                lru_q[idx_q]              <= !hit_way_q;
            end
        end
    end

    // fill and write rely on the way chosen by a completed probe
    assert property (@(posedge clk) disable iff (!arst_n_i)
        lk_rsp_valid_o |-> !(fill || write))
        else $error("fill or write issued while a probe response is pending");

endmodule

// File: src/dcache_pkg.sv
package dcache_pkg;

    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int STRB_W   = DATA_W / 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // command to the shared tag/data arrays
    typedef enum logic [1:0] {
        LK_PROBE = 2'd0,
        LK_FILL  = 2'd1,
        LK_WRITE = 2'd2
    } lk_op_e;

endpackage

// File: src/dcache_store_ctrl.sv
`timescale 1ns/1ps

module dcache_store_ctrl
    import dcache_pkg::*;
(
    input  logic   clk, arst_n_i,
    input  logic   st_valid_i,
    output logic   st_ready_o,
    input  addr_t  st_addr_i,
    input  data_t  st_data_i,
    input  strb_t  st_strb_i,
    output logic   st_done_o,
    output logic   arb_req_o,
    input  logic   grant_i,
    output logic   lk_valid_o,
    output lk_op_e lk_op_o,
    output addr_t  lk_addr_o,
    output data_t  lk_data_o,
    output strb_t  lk_strb_o,
    input  logic   lk_rsp_valid_i, lk_hit_i, lk_wb_need_i,
    input  addr_t  lk_wb_addr_i,
    input  data_t  lk_wb_data_i,
    output logic   mem_req_valid_o,
    input  logic   mem_req_ready_i,
    output logic   mem_req_write_o,
    output addr_t  mem_req_addr_o,
    output data_t  mem_req_data_o,
    input  logic   mem_rsp_valid_i,
    input  data_t  mem_rsp_data_i
);

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT_GRANT, S_PROBE, S_WRITE, S_WB, S_REFILL, S_DONE
    } state_e;

    state_e state_q;
    logic   rd_sent_q;
    addr_t  addr_q, wb_addr_q;
    data_t  data_q, wb_data_q;
    strb_t  strb_q;

    assign st_ready_o = (state_q == S_IDLE);
    assign st_done_o  = (state_q == S_DONE);
    assign arb_req_o  = (state_q != S_IDLE);

    assign lk_valid_o = ((state_q == S_WAIT_GRANT) && grant_i) ||
                        ((state_q == S_REFILL) && mem_rsp_valid_i) ||
                        (state_q == S_WRITE);
    assign lk_op_o    = (state_q == S_REFILL) ? LK_FILL :
                        (state_q == S_WRITE)  ? LK_WRITE : LK_PROBE;
    assign lk_addr_o  = addr_q;
    assign lk_data_o  = (state_q == S_REFILL) ? mem_rsp_data_i : data_q;
    assign lk_strb_o  = strb_q;

    assign mem_req_valid_o = (state_q == S_WB) || ((state_q == S_REFILL) && !rd_sent_q);
    assign mem_req_write_o = (state_q == S_WB);
    assign mem_req_addr_o  = (state_q == S_WB) ? wb_addr_q :
                             {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_req_data_o  = wb_data_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= S_IDLE;
            rd_sent_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE:
                    if (st_valid_i)
                        state_q <= S_WAIT_GRANT;
                S_WAIT_GRANT:
                    if (grant_i)
                        state_q <= S_PROBE;
                S_PROBE:
                    if (lk_rsp_valid_i)
                        state_q <= lk_hit_i ? S_WRITE : lk_wb_need_i ? S_WB : S_REFILL;
                S_WRITE:
                    state_q <= S_DONE;
                S_WB:
                    if (mem_req_ready_i)
                        state_q <= S_REFILL;
                S_REFILL: begin
                    if (mem_req_valid_o && mem_req_ready_i)
                        rd_sent_q <= 1'b1;
                    // line is now resident, probe again to merge
                    if (mem_rsp_valid_i) begin
                        rd_sent_q <= 1'b0;
                        state_q   <= S_WAIT_GRANT;
                    end
                end
                default:
                    state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st_valid_i && st_ready_o) begin
            addr_q <= st_addr_i;
            data_q <= st_data_i;
            strb_q <= st_strb_i;
        end
        if ((state_q == S_PROBE) && lk_rsp_valid_i) begin
            wb_addr_q <= lk_wb_addr_i;
            wb_data_q <= lk_wb_data_i;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o &&
            $stable(mem_req_write_o) && $stable(mem_req_addr_o) && $stable(mem_req_data_o))
        else $error("store memory request changed under back-pressure");

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic  clk, arst_n_i,
    input  logic  ld_valid_i,
    output logic  ld_ready_o,
    input  addr_t ld_addr_i,
    output logic  ld_resp_valid_o,
    output data_t ld_data_o,
    input  logic  st_valid_i,
    output logic  st_ready_o,
    input  addr_t st_addr_i,
    input  data_t st_data_i,
    input  strb_t st_strb_i,
    output logic  st_done_o,
    output logic  mem_req_valid_o,
    input  logic  mem_req_ready_i,
    output logic  mem_req_write_o,
    output addr_t mem_req_addr_o,
    output data_t mem_req_data_o,
    input  logic  mem_rsp_valid_i,
    input  data_t mem_rsp_data_i
);

    logic   ld_arb_req, st_arb_req, ld_grant, st_grant;
    logic   ld_lk_valid, st_lk_valid, lk_valid;
    lk_op_e ld_lk_op, st_lk_op, lk_op;
    addr_t  ld_lk_addr, st_lk_addr, lk_addr;
    data_t  ld_lk_data, st_lk_data, lk_data;
    strb_t  st_lk_strb, lk_strb;
    logic   lk_rsp_valid, lk_hit, lk_wb_need;
    data_t  lk_rdata, lk_wb_data;
    addr_t  lk_wb_addr;
    logic   ld_mem_valid, ld_mem_ready, ld_mem_write;
    logic   st_mem_valid, st_mem_ready, st_mem_write;
    addr_t  ld_mem_addr, st_mem_addr;
    data_t  ld_mem_data, st_mem_data;

    // both controllers see the shared response wires
    dcache_load_ctrl load_ctrl_i (
        .clk (clk), .arst_n_i (arst_n_i),
        .ld_valid_i (ld_valid_i), .ld_ready_o (ld_ready_o), .ld_addr_i (ld_addr_i),
        .ld_resp_valid_o (ld_resp_valid_o), .ld_data_o (ld_data_o),
        .arb_req_o (ld_arb_req), .grant_i (ld_grant),
        .lk_valid_o (ld_lk_valid), .lk_op_o (ld_lk_op),
        .lk_addr_o (ld_lk_addr), .lk_data_o (ld_lk_data),
        .lk_rsp_valid_i (lk_rsp_valid), .lk_hit_i (lk_hit), .lk_rdata_i (lk_rdata),
        .lk_wb_need_i (lk_wb_need), .lk_wb_addr_i (lk_wb_addr), .lk_wb_data_i (lk_wb_data),
        .mem_req_valid_o (ld_mem_valid), .mem_req_ready_i (ld_mem_ready),
        .mem_req_write_o (ld_mem_write), .mem_req_addr_o (ld_mem_addr),
        .mem_req_data_o (ld_mem_data),
        .mem_rsp_valid_i (mem_rsp_valid_i), .mem_rsp_data_i (mem_rsp_data_i)
    );

    dcache_store_ctrl store_ctrl_i (
        .clk (clk), .arst_n_i (arst_n_i),
        .st_valid_i (st_valid_i), .st_ready_o (st_ready_o), .st_addr_i (st_addr_i),
        .st_data_i (st_data_i), .st_strb_i (st_strb_i), .st_done_o (st_done_o),
        .arb_req_o (st_arb_req), .grant_i (st_grant),
        .lk_valid_o (st_lk_valid), .lk_op_o (st_lk_op), .lk_addr_o (st_lk_addr),
        .lk_data_o (st_lk_data), .lk_strb_o (st_lk_strb),
        .lk_rsp_valid_i (lk_rsp_valid), .lk_hit_i (lk_hit), .lk_wb_need_i (lk_wb_need),
        .lk_wb_addr_i (lk_wb_addr), .lk_wb_data_i (lk_wb_data),
        .mem_req_valid_o (st_mem_valid), .mem_req_ready_i (st_mem_ready),
        .mem_req_write_o (st_mem_write), .mem_req_addr_o (st_mem_addr),
        .mem_req_data_o (st_mem_data),
        .mem_rsp_valid_i (mem_rsp_valid_i), .mem_rsp_data_i (mem_rsp_data_i)
    );

    dcache_arbiter arbiter_i (
        .clk (clk), .arst_n_i (arst_n_i),
        .ld_arb_req_i (ld_arb_req), .st_arb_req_i (st_arb_req),
        .ld_grant_o (ld_grant), .st_grant_o (st_grant),
        .ld_lk_valid_i (ld_lk_valid), .ld_lk_op_i (ld_lk_op),
        .ld_lk_addr_i (ld_lk_addr), .ld_lk_data_i (ld_lk_data),
        .st_lk_valid_i (st_lk_valid), .st_lk_op_i (st_lk_op), .st_lk_addr_i (st_lk_addr),
        .st_lk_data_i (st_lk_data), .st_lk_strb_i (st_lk_strb),
        .lk_valid_o (lk_valid), .lk_op_o (lk_op), .lk_addr_o (lk_addr),
        .lk_data_o (lk_data), .lk_strb_o (lk_strb),
        .ld_mem_req_valid_i (ld_mem_valid), .ld_mem_req_write_i (ld_mem_write),
        .ld_mem_req_ready_o (ld_mem_ready), .ld_mem_req_addr_i (ld_mem_addr),
        .ld_mem_req_data_i (ld_mem_data),
        .st_mem_req_valid_i (st_mem_valid), .st_mem_req_write_i (st_mem_write),
        .st_mem_req_ready_o (st_mem_ready), .st_mem_req_addr_i (st_mem_addr),
        .st_mem_req_data_i (st_mem_data),
        .mem_req_valid_o (mem_req_valid_o), .mem_req_ready_i (mem_req_ready_i),
        .mem_req_write_o (mem_req_write_o), .mem_req_addr_o (mem_req_addr_o),
        .mem_req_data_o (mem_req_data_o)
    );

    dcache_lookup lookup_i (
        .clk (clk), .arst_n_i (arst_n_i),
        .lk_valid_i (lk_valid), .lk_op_i (lk_op), .lk_addr_i (lk_addr),
        .lk_data_i (lk_data), .lk_strb_i (lk_strb),
        .lk_rsp_valid_o (lk_rsp_valid), .lk_hit_o (lk_hit), .lk_rdata_o (lk_rdata),
        .lk_wb_need_o (lk_wb_need), .lk_wb_addr_o (lk_wb_addr), .lk_wb_data_o (lk_wb_data)
    );

endmodule

// File: src/dcache_way_ram.sv
`timescale 1ns/1ps

module dcache_way_ram
    import dcache_pkg::*;
#(
    parameter type payload_t = data_t
) (
    input  logic     clk,
    input  index_t   rd_index_i,
    input  logic     wr_en_i,
    input  index_t   wr_index_i,
    input  payload_t wr_data_i,
    output payload_t rd_data_o
);

    payload_t mem [NUM_SETS];

    // read returns the old entry when the same set is written
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_index_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_index_i];
    end

endmodule

// File: verification/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
;

    localparam int    TIMEOUT_CYC = 300;
    localparam data_t MEM_PATTERN = 64'h5a5a_c3c3_0f0f_9696;

    logic  clk = 1'b0;
    logic  arst_n_i;
    logic  ld_valid_i;
    logic  ld_ready_o;
    addr_t ld_addr_i;
    logic  ld_resp_valid_o;
    data_t ld_data_o;
    logic  st_valid_i;
    logic  st_ready_o;
    addr_t st_addr_i;
    data_t st_data_i;
    strb_t st_strb_i;
    logic  st_done_o;
    logic  mem_req_valid_o;
    logic  mem_req_ready_i;
    logic  mem_req_write_o;
    addr_t mem_req_addr_o;
    data_t mem_req_data_o;
    logic  mem_rsp_valid_i;
    data_t mem_rsp_data_i;

    // memory model state
    data_t  mem_words [addr_t];
    addr_t  wb_addr_log [$];
    data_t  wb_data_log [$];
    int     rd_count = 0;
    int     wr_count = 0;
    int     rd_wait;
    addr_t  rd_addr;
    logic   stall_en = 1'b0;
    integer seed = 32'h65e6_6573;

    dcache_top dcache_top_i (.*);

    always #4 clk = ~clk;

    function automatic data_t pattern_word(input addr_t a);
        return a ^ MEM_PATTERN;
    endfunction

    function automatic data_t apply_strb(input data_t old, input data_t wdata, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic addr_t line_addr(input tag_t t, input index_t s);
        return {t, s, {OFFSET_W{1'b0}}};
    endfunction

    task automatic check_eq(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on timeout");
    endtask

    // memory side, reads answered 2 to 5 cycles after the handshake
    initial begin : mem_model
        mem_req_ready_i = 1'b1;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        rd_wait         = 0;
        rd_addr         = '0;
        forever begin
            @(negedge clk);
            mem_rsp_valid_i = 1'b0;
            if (rd_wait > 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    mem_rsp_valid_i = 1'b1;
                    mem_rsp_data_i  = mem_words.exists(rd_addr) ? mem_words[rd_addr]
                                                                : pattern_word(rd_addr);
                end
            end
            mem_req_ready_i = stall_en ? ($unsigned($random(seed)) % 3 != 0) : 1'b1;
            // valid and ready are both stable here, the handshake lands on the next edge
            if (mem_req_valid_o && mem_req_ready_i) begin
                if (mem_req_write_o) begin
                    mem_words[mem_req_addr_o] = mem_req_data_o;
                    wb_addr_log.push_back(mem_req_addr_o);
                    wb_data_log.push_back(mem_req_data_o);
                    wr_count++;
                end else begin
                    rd_addr = mem_req_addr_o;
                    rd_wait = 2 + int'($unsigned($random(seed)) % 4);
                    rd_count++;
                end
            end
        end
    end

    task automatic load_word(input addr_t a, output data_t d, output int lat);
        int n;
        n = 0;
        while (!ld_ready_o) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYC) timeout_abort("ld_ready_o");
        end
        ld_valid_i = 1'b1;
        ld_addr_i  = a;
        @(negedge clk);
        ld_valid_i = 1'b0;
        n = 0;
        while (!ld_resp_valid_o) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYC) timeout_abort("the load response");
        end
        d   = ld_data_o;
        lat = n + 1;
        @(negedge clk);
    endtask

    task automatic store_word(input addr_t a, input data_t wdata, input strb_t strb);
        int n;
        n = 0;
        while (!st_ready_o) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYC) timeout_abort("st_ready_o");
        end
        st_valid_i = 1'b1;
        st_addr_i  = a;
        st_data_i  = wdata;
        st_strb_i  = strb;
        @(negedge clk);
        st_valid_i = 1'b0;
        n = 0;
        while (!st_done_o) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYC) timeout_abort("st_done_o");
        end
        @(negedge clk);
    endtask

    task automatic test_cold_miss_hit();
        addr_t a;
        data_t got;
        int    r0, w0, lat;
        a = line_addr(55'h10, 6'd1);
        check_eq("ld_ready_o after reset", data_t'(ld_ready_o), 64'd1);
        check_eq("st_ready_o after reset", data_t'(st_ready_o), 64'd1);
        r0 = rd_count;
        w0 = wr_count;
        load_word(a, got, lat);
        check_eq("cold load data", got, pattern_word(a));
        check_eq("cold load reads", data_t'(rd_count - r0), 64'd1);
        load_word(a, got, lat);
        check_eq("hit load data", got, pattern_word(a));
        check_eq("hit load latency", data_t'(lat), 64'd3);
        check_eq("hit load reads", data_t'(rd_count - r0), 64'd1);
        check_eq("hit load writes", data_t'(wr_count - w0), 64'd0);
    endtask

    task automatic test_store_hit();
        addr_t a;
        data_t got, wdata;
        strb_t strb;
        int    r0, w0, lat;
        a     = line_addr(55'h21, 6'd2);
        wdata = 64'h1122_3344_5566_7788;
        strb  = 8'b1010_0101;
        load_word(a, got, lat);
        check_eq("store hit preload", got, pattern_word(a));
        r0 = rd_count;
        w0 = wr_count;
        store_word(a, wdata, strb);
        load_word(a, got, lat);
        check_eq("store hit merge", got, apply_strb(pattern_word(a), wdata, strb));
        check_eq("store hit reads", data_t'(rd_count - r0), 64'd0);
        check_eq("store hit writes", data_t'(wr_count - w0), 64'd0);
    endtask

    task automatic test_store_miss(input index_t s);
        addr_t a;
        data_t got, wdata;
        int    r0, w0, lat;
        a     = line_addr(55'h32, s);
        wdata = 64'hdead_beef_cafe_f00d;
        r0    = rd_count;
        w0    = wr_count;
        store_word(a, wdata, 8'h0f);
        check_eq("store miss reads", data_t'(rd_count - r0), 64'd1);
        check_eq("store miss writes", data_t'(wr_count - w0), 64'd0);
        load_word(a, got, lat);
        check_eq("store miss merge", got, apply_strb(pattern_word(a), wdata, 8'h0f));
        check_eq("store miss reload reads", data_t'(rd_count - r0), 64'd1);
    endtask

    task automatic test_evict(input index_t s);
        addr_t x, y, z;
        data_t got, x_exp, y_exp;
        int    r0, w0, lat;
        x     = line_addr(55'h100, s);
        y     = line_addr(55'h200, s);
        z     = line_addr(55'h300, s);
        x_exp = apply_strb(pattern_word(x), 64'haaaa_0000_bbbb_1111, 8'hf0);
        y_exp = apply_strb(pattern_word(y), 64'h1234_5678_9abc_def0, 8'h3c);
        store_word(x, 64'haaaa_0000_bbbb_1111, 8'hf0);
        store_word(y, 64'h1234_5678_9abc_def0, 8'h3c);
        // x becomes most recent, so y is the victim for z
        load_word(x, got, lat);
        check_eq("evict touch data", got, x_exp);
        r0 = rd_count;
        w0 = wr_count;
        load_word(z, got, lat);
        check_eq("evict third line data", got, pattern_word(z));
        check_eq("evict reads", data_t'(rd_count - r0), 64'd1);
        check_eq("evict writes", data_t'(wr_count - w0), 64'd1);
        check_eq("write-back address", wb_addr_log[$], y);
        check_eq("write-back data", wb_data_log[$], y_exp);
        // z took the y way, x is now the LRU way and goes out
        w0 = wr_count;
        load_word(y, got, lat);
        check_eq("reload of evicted line", got, y_exp);
        check_eq("reload writes", data_t'(wr_count - w0), 64'd1);
        check_eq("second write-back address", wb_addr_log[$], x);
        check_eq("second write-back data", wb_data_log[$], x_exp);
    endtask

    task automatic test_concurrent();
        addr_t la, sa;
        data_t got, ld_got, wdata;
        logic  ld_seen, st_seen;
        int    n, lat;
        la      = line_addr(55'h60, 6'd7);
        sa      = line_addr(55'h61, 6'd8);
        wdata   = 64'h0bad_f00d_1357_2468;
        ld_seen = 1'b0;
        st_seen = 1'b0;
        ld_got  = '0;
        n = 0;
        while (!(ld_ready_o && st_ready_o)) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYC) timeout_abort("both ports to be ready");
        end
        ld_valid_i = 1'b1;
        ld_addr_i  = la;
        st_valid_i = 1'b1;
        st_addr_i  = sa;
        st_data_i  = wdata;
        st_strb_i  = 8'hc3;
        @(negedge clk);
        ld_valid_i = 1'b0;
        st_valid_i = 1'b0;
        n = 0;
        while (!(ld_seen && st_seen)) begin
            if (ld_resp_valid_o) begin
                ld_seen = 1'b1;
                ld_got  = ld_data_o;
            end
            if (st_done_o) begin
                st_seen = 1'b1;
            end
            @(negedge clk);
            n++;
            if (n > TIMEOUT_CYC) timeout_abort("the concurrent load and store");
        end
        check_eq("concurrent load data", ld_got, pattern_word(la));
        load_word(sa, got, lat);
        check_eq("concurrent store merge", got, apply_strb(pattern_word(sa), wdata, 8'hc3));
    endtask

    initial begin
        arst_n_i   = 1'b0;
        ld_valid_i = 1'b0;
        ld_addr_i  = '0;
        st_valid_i = 1'b0;
        st_addr_i  = '0;
        st_data_i  = '0;
        st_strb_i  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);

        test_cold_miss_hit();
        test_store_hit();
        test_store_miss(6'd3);
        test_evict(6'd4);
        // same sequences again under memory back-pressure
        stall_en = 1'b1;
        test_store_miss(6'd5);
        test_evict(6'd6);
        stall_en = 1'b0;
        test_concurrent();

        $display("TEST PASSED");
        $finish;
    end

endmodule
